//--- verilog.f
+incdir+dv
hdl/datapath_pkg.sv
hdl/sync_register_file.sv
hdl/operand_fetch_stage.sv
hdl/alu_stage.sv
hdl/writeback_stage.sv
hdl/datapath_top.sv
dv/datapath_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary -j 0
TOP      = datapath_tb
FILELIST = verilog.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(BUILD)

//--- dv/datapath_model.svh
`ifndef DATAPATH_MODEL_SVH
`define DATAPATH_MODEL_SVH

// architectural registers as the instruction rules define them.
logic [datapath_pkg::data_width-1:0] model_regs [4];
datapath_pkg::result_t               expected_q [$];      // retire order.
int unsigned                         expected_tag_q [$];  // edge each one was taken.

function automatic void model_clear();
    for (int i = 0; i < 4; i++) begin
        model_regs[i] = '0;  // reset value.
    end
    expected_q.delete();
    expected_tag_q.delete();
endfunction

// executes one taken instruction in program order.
function automatic void model_take(input datapath_pkg::instr_t ins, input int unsigned tag);
    logic [datapath_pkg::data_width-1:0] l;
    logic [datapath_pkg::data_width-1:0] r;
    datapath_pkg::result_t               exp;
    l               = model_regs[ins.src_l];
    r               = model_regs[ins.src_r];
    exp.dest        = ins.dest;
    exp.reg_write   = (ins.opcode != datapath_pkg::op_cmp);  // cmp is flags only.
    exp.flags.carry = 1'b0;
    case (ins.opcode)
        datapath_pkg::op_add: begin
            exp.value       = l + r;
            exp.flags.carry = (exp.value < l);  // sum wrapped past 8 bits.
        end
        datapath_pkg::op_sub, datapath_pkg::op_cmp: begin
            exp.value       = l - r;
            exp.flags.carry = (l < r);  // borrow.
        end
        datapath_pkg::op_and:      exp.value = l & r;
        datapath_pkg::op_or:       exp.value = l | r;
        datapath_pkg::op_xor:      exp.value = l ^ r;
        datapath_pkg::op_load_imm: exp.value = ins.imm;
        default:                   exp.value = l;  // pass.
    endcase
    exp.flags.zero = (exp.value == '0);
    if (exp.reg_write) begin
        model_regs[ins.dest] = exp.value;
    end
    expected_q.push_back(exp);
    expected_tag_q.push_back(tag);
endfunction

`endif

//--- dv/datapath_tb.sv
`default_nettype none
`timescale 1ns/1ps

module datapath_tb;

    localparam int reset_cycles = 2;
    localparam int n_random     = 200;
    localparam int n_chain      = 108;     // (d+1) * 12 for d = 1..3.
    localparam int n_cmp        = 27;
    localparam int n_gap        = 100;     // slots, idle ones included.
    localparam int n_idle       = 4 + 5 * 5;  // watch window plus five drains.
    localparam int cycle_limit  = reset_cycles + 4 + n_random + n_chain + n_cmp + n_gap
                                  + n_idle + 3 + 20;  // 3 stages, 20 margin.

    logic                  _pulse = 1'b0;
    logic                  reset;
    logic                  instr_valid;
    datapath_pkg::instr_t  instr;
    logic                  result_valid;
    datapath_pkg::result_t result;
    int unsigned           cycle       = 0;  // rising edges so far.
    int unsigned           pass_count  = 0;
    int unsigned           error_count = 0;
    int unsigned           late_count  = 0;
    int unsigned           retired     = 0;
    logic [31:0]           lfsr_state  = 32'd83679;

    `include "datapath_model.svh"

    datapath_top dut0 (
        ._pulse       (_pulse),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_valid (result_valid),
        .result       (result)
    );

    always #20 _pulse = ~_pulse;  // 40 ns period.

    always @(posedge _pulse) cycle <= cycle + 1;

    // galois form, taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] nxt;
        nxt = state >> 1;
        if (state[0]) nxt = nxt ^ 32'h8020_0003;
        return nxt;
    endfunction

    function automatic logic [7:0] random_bits(input int count);
        logic [7:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);  // one step per bit.
            bits       = {bits[6:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic datapath_pkg::instr_t random_instr();
        datapath_pkg::instr_t ins;
        logic [7:0]           bits;
        bits       = random_bits(3);
        ins.opcode = datapath_pkg::opcode_t'(bits[2:0]);
        bits       = random_bits(2);
        ins.dest   = bits[1:0];
        bits       = random_bits(2);
        ins.src_l  = bits[1:0];
        bits       = random_bits(2);
        ins.src_r  = bits[1:0];
        ins.imm    = random_bits(8);
        return ins;
    endfunction

    function automatic datapath_pkg::instr_t make_instr(input datapath_pkg::opcode_t op,
            input logic [1:0] dest, input logic [1:0] src_l, input logic [1:0] src_r,
            input logic [7:0] imm);
        datapath_pkg::instr_t ins;
        ins.opcode = op;
        ins.dest   = dest;
        ins.src_l  = src_l;
        ins.src_r  = src_r;
        ins.imm    = imm;
        return ins;
    endfunction

    task automatic drive_instr(input datapath_pkg::instr_t ins);
        @(posedge _pulse);
        #2;
        instr_valid = 1'b1;
        instr       = ins;
        model_take(ins, cycle + 1);  // sampled at the next edge.
    endtask

    task automatic drive_idle();
        @(posedge _pulse);
        #2;
        instr_valid = 1'b0;  // bubble.
    endtask

    task automatic drain();
        int unsigned waited;
        waited = 0;
        drive_idle();
        while (expected_q.size() != 0 && waited < 4) begin  // results are two edges behind.
            drive_idle();
            waited++;
        end
    endtask

    task automatic check_result(input datapath_pkg::result_t actual,
            input datapath_pkg::result_t expected);
        logic ok;
        ok = 1'b1;
        if (actual.dest !== expected.dest) begin
            $display("FAILED result.dest: got 0x%h, expected 0x%h", actual.dest, expected.dest);
            ok = 1'b0;
        end
        if (actual.reg_write !== expected.reg_write) begin
            $display("FAILED result.reg_write: got 0x%h, expected 0x%h",
                     actual.reg_write, expected.reg_write);
            ok = 1'b0;
        end
        if (actual.value !== expected.value) begin
            $display("FAILED result.value: got 0x%h, expected 0x%h", actual.value, expected.value);
            ok = 1'b0;
        end
        if (ok) pass_count++;
        else error_count++;
    endtask

    task automatic check_flags(input datapath_pkg::flags_t actual,
            input datapath_pkg::flags_t expected);
        if (actual !== expected) begin
            $display("FAILED result.flags: got 0x%h, expected 0x%h", actual, expected);
            error_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int unsigned start);
        if (error_count == start) $display("test %0d %s: ok", num, name);
        else $display("test %0d %s: %0d errors", num, name, error_count - start);
    endtask

    // outputs are settled mid-cycle.
    always @(negedge _pulse) begin
        datapath_pkg::result_t exp;
        int unsigned           tag;
        if (!reset && result_valid) begin
            if (expected_q.size() == 0) begin
                $display("result_valid high at edge %0d with no instruction outstanding", cycle);
                error_count++;
            end else begin
                exp = expected_q.pop_front();
                tag = expected_tag_q.pop_front();
                check_result(result, exp);
                check_flags(result.flags, exp.flags);
                if (cycle != tag + 2) begin  // fixed two-edge latency.
                    $display("instruction taken at edge %0d retired at edge %0d, not %0d",
                             tag, cycle, tag + 2);
                    late_count++;
                    error_count++;
                end
                retired++;
            end
        end
    end

    initial begin
        while (cycle < cycle_limit) @(posedge _pulse);
        $display("timeout: run still going after %0d cycles", cycle);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        datapath_pkg::instr_t ins;
        logic [7:0]           bits;
        logic [1:0]           r;
        int unsigned          start;
        int unsigned          leftover;
        int unsigned          fail_total;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        model_clear();
        repeat (reset_cycles) @(posedge _pulse);
        #2;
        reset = 1'b0;

        start = error_count;
        repeat (4) drive_idle();  // monitor flags any result here.
        for (int i = 0; i < 4; i++) begin
            drive_instr(make_instr(datapath_pkg::op_pass, i[1:0], i[1:0], 2'd0, 8'h00));
        end
        drain();
        report_test(1, "reset state", start);

        start = error_count;
        repeat (n_random) drive_instr(random_instr());
        drain();
        report_test(2, "random full rate", start);

        start = error_count;
        for (int d = 1; d <= 3; d++) begin
            for (int p = 0; p < 3; p++) begin  // left, right, both ports.
                repeat (4) begin
                    bits     = random_bits(2);
                    r        = bits[1:0];
                    ins      = random_instr();
                    ins.dest = r;
                    if (ins.opcode == datapath_pkg::op_cmp) ins.opcode = datapath_pkg::op_load_imm;
                    drive_instr(ins);
                    for (int f = 1; f < d; f++) begin
                        ins      = random_instr();
                        ins.dest = r + 2'd1;  // keeps off the chain register.
                        drive_instr(ins);
                    end
                    ins = random_instr();
                    if (ins.opcode == datapath_pkg::op_load_imm) ins.opcode = datapath_pkg::op_add;
                    if (p != 1) ins.src_l = r;
                    if (p != 0) ins.src_r = r;
                    drive_instr(ins);
                end
            end
        end
        drain();
        report_test(3, "forwarding chains", start);

        start = error_count;
        drive_instr(make_instr(datapath_pkg::op_load_imm, 2'd0, 2'd0, 2'd0, 8'hf0));
        drive_instr(make_instr(datapath_pkg::op_load_imm, 2'd1, 2'd0, 2'd0, 8'h20));
        drive_instr(make_instr(datapath_pkg::op_add, 2'd2, 2'd0, 2'd0, 8'h00));  // overflow.
        drive_instr(make_instr(datapath_pkg::op_cmp, 2'd0, 2'd1, 2'd0, 8'h00));  // borrow.
        drive_instr(make_instr(datapath_pkg::op_cmp, 2'd1, 2'd0, 2'd1, 8'h00));
        drive_instr(make_instr(datapath_pkg::op_cmp, 2'd2, 2'd1, 2'd1, 8'h00));  // zero set.
        drive_instr(make_instr(datapath_pkg::op_sub, 2'd3, 2'd1, 2'd0, 8'h00));
        for (int i = 0; i < 4; i++) begin
            drive_instr(make_instr(datapath_pkg::op_pass, i[1:0], i[1:0], 2'd0, 8'h00));
        end
        repeat (8) begin
            ins        = random_instr();
            ins.opcode = datapath_pkg::op_cmp;
            drive_instr(ins);
            drive_instr(make_instr(datapath_pkg::op_pass, ins.dest, ins.dest, 2'd0, 8'h00));
        end
        drain();
        report_test(4, "compare and flags", start);

        start = error_count;
        repeat (n_gap) begin
            bits = random_bits(2);
            if (bits == 8'd0) begin
                drive_idle();
            end else begin
                drive_instr(random_instr());
            end
        end
        drain();
        report_test(5, "valid gaps", start);

        if (late_count == 0) $display("test 6 retire latency: ok, %0d results", retired);
        else $display("test 6 retire latency: %0d results off time", late_count);
        leftover = expected_q.size();
        if (leftover != 0) $display("%0d expected results never retired", leftover);
        fail_total = error_count + ((leftover != 0) ? 1 : 0);
        $display("checks passed %0d, failed %0d", pass_count, fail_total);
        if (fail_total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/datapath_top.sv
`default_nettype none
`timescale 1ns/1ps

module datapath_top (
    input  wire logic                 _pulse,
    input  wire logic                 reset,
    input  wire logic                 instr_valid,
    input  wire datapath_pkg::instr_t instr,
    output logic                      result_valid,
    output datapath_pkg::result_t     result
);

    logic [datapath_pkg::reg_addr_width-1:0] rd_l_addr;  // fetch to file.
    logic [datapath_pkg::reg_addr_width-1:0] rd_r_addr;
    logic [datapath_pkg::data_width-1:0]     rd_l_data;  // file to fetch.
    logic [datapath_pkg::data_width-1:0]     rd_r_data;
    logic                                    wr_en;      // writeback to file.
    logic [datapath_pkg::reg_addr_width-1:0] wr_addr;
    logic [datapath_pkg::data_width-1:0]     wr_data;
    datapath_pkg::fetch_word_t               fetch_word;
    datapath_pkg::alu_word_t                 alu_next;   // one-older forward.
    datapath_pkg::alu_word_t                 alu_word;   // two-older forward.

    operand_fetch_stage u_fetch (
        ._pulse      (_pulse),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rd_l_addr   (rd_l_addr),
        .rd_r_addr   (rd_r_addr),
        .rd_l_data   (rd_l_data),
        .rd_r_data   (rd_r_data),
        .alu_next    (alu_next),
        .alu_word    (alu_word),
        .fetch_word  (fetch_word)
    );

    alu_stage u_alu (
        ._pulse     (_pulse),
        .reset      (reset),
        .fetch_word (fetch_word),
        .alu_next   (alu_next),
        .alu_word   (alu_word)
    );

    writeback_stage u_writeback (
        ._pulse       (_pulse),
        .reset        (reset),
        .alu_word     (alu_word),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .result_valid (result_valid),
        .result       (result)
    );

    sync_register_file u_regfile (
        ._pulse    (_pulse),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_l_addr (rd_l_addr),
        .rd_l_data (rd_l_data),
        .rd_r_addr (rd_r_addr),
        .rd_r_data (rd_r_data)
    );

endmodule

`default_nettype wire

//--- hdl/writeback_stage.sv
`default_nettype none
`timescale 1ns/1ps

module writeback_stage (
    input  wire logic                               _pulse,
    input  wire logic                               reset,
    input  wire datapath_pkg::alu_word_t            alu_word,
    output logic                                    wr_en,
    output logic [datapath_pkg::reg_addr_width-1:0] wr_addr,
    output logic [datapath_pkg::data_width-1:0]     wr_data,
    output logic                                    result_valid,
    output datapath_pkg::result_t                   result
);

    logic [datapath_pkg::reg_addr_width-1:0] dest_q;  // retired payload.
    logic                                    reg_write_q;
    logic [datapath_pkg::data_width-1:0]     value_q;
    datapath_pkg::flags_t                    flags_q;  // last retired flags.

    assign wr_en   = alu_word.valid & alu_word.reg_write;  // cmp and bubbles skip the file.
    assign wr_addr = alu_word.dest;
    assign wr_data = alu_word.value;

    always_ff @(posedge _pulse) begin
        if (reset) begin
            result_valid <= 1'b0;
            flags_q      <= '0;  // flags start clear.
        end else begin
            result_valid <= alu_word.valid;  // one pulse per retire.
            if (alu_word.valid) begin
                flags_q <= alu_word.flags;  // held across bubbles.
            end
        end
        if (alu_word.valid) begin
            dest_q      <= alu_word.dest;
            reg_write_q <= alu_word.reg_write;
            value_q     <= alu_word.value;
        end
    end

    assign result.dest      = dest_q;
    assign result.reg_write = reg_write_q;
    assign result.value     = value_q;
    assign result.flags     = flags_q;  // equals this instruction's flags while valid.

endmodule

`default_nettype wire

//--- hdl/alu_stage.sv
`default_nettype none
`timescale 1ns/1ps

module alu_stage (
    input  wire logic                    _pulse,
    input  wire logic                    reset,
    input  wire datapath_pkg::fetch_word_t fetch_word,
    output datapath_pkg::alu_word_t      alu_next,
    output datapath_pkg::alu_word_t      alu_word
);

    logic [datapath_pkg::data_width:0]   sum_wide;   // 9-bit, top bit is carry.
    logic [datapath_pkg::data_width:0]   diff_wide;  // 9-bit, top bit is borrow.
    logic [datapath_pkg::data_width-1:0] value;
    logic                                carry;

    assign sum_wide  = {1'b0, fetch_word.operand_l} + {1'b0, fetch_word.operand_r};
    assign diff_wide = {1'b0, fetch_word.operand_l} - {1'b0, fetch_word.operand_r};

    always_comb begin
        value = fetch_word.operand_l;  // pass and load_imm.
        carry = 1'b0;                  // logic ops leave carry clear.
        case (fetch_word.opcode)
            datapath_pkg::op_add: begin
                value = sum_wide[datapath_pkg::data_width-1:0];
                carry = sum_wide[datapath_pkg::data_width];
            end
            datapath_pkg::op_sub, datapath_pkg::op_cmp: begin
                // cmp carries the difference too, but never writes it.
                value = diff_wide[datapath_pkg::data_width-1:0];
                carry = diff_wide[datapath_pkg::data_width];
            end
            datapath_pkg::op_and: value = fetch_word.operand_l & fetch_word.operand_r;
            datapath_pkg::op_or:  value = fetch_word.operand_l | fetch_word.operand_r;
            datapath_pkg::op_xor: value = fetch_word.operand_l ^ fetch_word.operand_r;
            default: begin
                value = fetch_word.operand_l;  // pass, load_imm.
                carry = 1'b0;
            end
        endcase
    end

    always_comb begin
        alu_next.valid       = fetch_word.valid;
        alu_next.dest        = fetch_word.dest;
        alu_next.reg_write   = fetch_word.reg_write;
        alu_next.value       = value;
        alu_next.flags.zero  = (value == '0);  // zero for every op.
        alu_next.flags.carry = carry;
    end

    always_ff @(posedge _pulse) begin
        alu_word <= alu_next;  // also the two-older forward source.
        if (reset) begin
            alu_word.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/operand_fetch_stage.sv
`default_nettype none
`timescale 1ns/1ps

module operand_fetch_stage (
    input  wire logic                                    _pulse,
    input  wire logic                                    reset,
    input  wire logic                                    instr_valid,
    input  wire datapath_pkg::instr_t                    instr,
    output logic [datapath_pkg::reg_addr_width-1:0]      rd_l_addr,
    output logic [datapath_pkg::reg_addr_width-1:0]      rd_r_addr,
    input  wire logic [datapath_pkg::data_width-1:0]     rd_l_data,
    input  wire logic [datapath_pkg::data_width-1:0]     rd_r_data,
    input  wire datapath_pkg::alu_word_t                 alu_next,
    input  wire datapath_pkg::alu_word_t                 alu_word,
    output datapath_pkg::fetch_word_t                    fetch_word
);

    datapath_pkg::fetch_word_t           fetch_next;  // decoded word for this edge.
    logic [datapath_pkg::data_width-1:0] fwd_l;       // left operand after forwarding.
    logic [datapath_pkg::data_width-1:0] fwd_r;

    // youngest producer wins: alu_next is one older, alu_word two older.
    function automatic logic [datapath_pkg::data_width-1:0] pick_operand(
        input logic [datapath_pkg::reg_addr_width-1:0] src,
        input logic [datapath_pkg::data_width-1:0]     file_data,
        input datapath_pkg::alu_word_t                 next_word,
        input datapath_pkg::alu_word_t                 held_word
    );
        logic [datapath_pkg::data_width-1:0] value;
        value = file_data;  // three or more older.
        if (held_word.valid && held_word.reg_write && held_word.dest == src) begin
            value = held_word.value;
        end
        if (next_word.valid && next_word.reg_write && next_word.dest == src) begin
            value = next_word.value;
        end
        return value;
    endfunction

    assign rd_l_addr = instr.src_l;  // file read is combinational.
    assign rd_r_addr = instr.src_r;

    assign fwd_l = pick_operand(instr.src_l, rd_l_data, alu_next, alu_word);
    assign fwd_r = pick_operand(instr.src_r, rd_r_data, alu_next, alu_word);

    always_comb begin
        fetch_next.valid     = instr_valid;
        fetch_next.opcode    = instr.opcode;
        fetch_next.dest      = instr.dest;
        fetch_next.reg_write = (instr.opcode != datapath_pkg::op_cmp);  // cmp is flags only.
        if (instr.opcode == datapath_pkg::op_load_imm) begin
            fetch_next.operand_l = instr.imm;  // alu passes l through.
            fetch_next.operand_r = instr.imm;
        end else begin
            fetch_next.operand_l = fwd_l;
            fetch_next.operand_r = fwd_r;
        end
    end

    always_ff @(posedge _pulse) begin
        fetch_word <= fetch_next;  // payload follows every edge.
        if (reset) begin
            fetch_word.valid <= 1'b0;  // bubble after reset.
        end
    end

endmodule

`default_nettype wire

//--- hdl/sync_register_file.sv
`default_nettype none
`timescale 1ns/1ps

module sync_register_file (
    input  wire logic                                    _pulse,
    input  wire logic                                    reset,
    input  wire logic                                    wr_en,
    input  wire logic [datapath_pkg::reg_addr_width-1:0] wr_addr,
    input  wire logic [datapath_pkg::data_width-1:0]     wr_data,
    input  wire logic [datapath_pkg::reg_addr_width-1:0] rd_l_addr,
    output logic [datapath_pkg::data_width-1:0]          rd_l_data,
    input  wire logic [datapath_pkg::reg_addr_width-1:0] rd_r_addr,
    output logic [datapath_pkg::data_width-1:0]          rd_r_data
);

    localparam int reg_count = 1 << datapath_pkg::reg_addr_width;  // 4 entries.

    logic [datapath_pkg::data_width-1:0] regs [reg_count];  // architectural registers.

    always_ff @(posedge _pulse) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;  // all registers start at zero.
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;  // one write per edge.
        end
    end

    // no bypass here. the fetch stage forwards in-flight results,
    // so a same-edge write never has to be seen through the file.
    assign rd_l_data = regs[rd_l_addr];  // left read port.
    assign rd_r_data = regs[rd_r_addr];  // right read port.

endmodule

`default_nettype wire

//--- hdl/datapath_pkg.sv
`default_nettype none

package datapath_pkg;

    localparam int data_width     = 8;  // operand and result width.
    localparam int reg_addr_width = 2;  // four registers.

    typedef enum logic [2:0] {
        op_add      = 3'd0,  // l + r, carry out.
        op_sub      = 3'd1,  // l - r, carry is borrow.
        op_and      = 3'd2,
        op_or       = 3'd3,
        op_xor      = 3'd4,
        op_pass     = 3'd5,  // copies l.
        op_load_imm = 3'd6,  // writes the immediate.
        op_cmp      = 3'd7   // l - r, flags only.
    } opcode_t;

    typedef struct packed {
        logic zero;   // result was zero.
        logic carry;  // carry out, or borrow on sub and cmp.
    } flags_t;

    typedef struct packed {
        opcode_t                   opcode;
        logic [reg_addr_width-1:0] dest;
        logic [reg_addr_width-1:0] src_l;
        logic [reg_addr_width-1:0] src_r;
        logic [data_width-1:0]     imm;
    } instr_t;

    // operand fetch stage register.
    typedef struct packed {
        logic                      valid;
        opcode_t                   opcode;
        logic [reg_addr_width-1:0] dest;
        logic                      reg_write;  // low only for cmp.
        logic [data_width-1:0]     operand_l;  // imm already selected.
        logic [data_width-1:0]     operand_r;
    } fetch_word_t;

    typedef struct packed {
        logic                      valid;
        logic [reg_addr_width-1:0] dest;
        logic                      reg_write;
        logic [data_width-1:0]     value;
        flags_t                    flags;
    } alu_word_t;

    typedef struct packed {
        logic [reg_addr_width-1:0] dest;
        logic                      reg_write;
        logic [data_width-1:0]     value;
        flags_t                    flags;  // flags of this instruction.
    } result_t;

endpackage

`default_nettype wire
